/* src.f */
+incdir+dv
source/rv32_types_pkg.sv
source/rv32_ctrl_pkg.sv
source/rv32_ex_wb_if.sv
source/rv32_alu.sv
source/rv32_forward.sv
source/rv32_execute.sv
source/rv32_writeback.sv
source/rv32_exec_top.sv
dv/tb_rv32_exec_top.sv

/* Bender.yml */
package:
  name: rv32_exec

sources:
  - files:
      - source/rv32_types_pkg.sv
      - source/rv32_ctrl_pkg.sv
      - source/rv32_ex_wb_if.sv
      - source/rv32_alu.sv
      - source/rv32_forward.sv
      - source/rv32_execute.sv
      - source/rv32_writeback.sv
      - source/rv32_exec_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_rv32_exec_top.sv

/* dv/rv32_exec_model.svh */
`ifndef RV32_EXEC_MODEL_SVH
`define RV32_EXEC_MODEL_SVH

// mirror of the execute stage register.
reg_addr_t  exp_ex_rd;
logic       exp_ex_wbk;
word_t      exp_ex_result, exp_ex_store, exp_ex_bpc;
logic       exp_ex_read, exp_ex_write, exp_ex_zext;
mem_width_t exp_ex_width;
branch_op_t exp_ex_branch;

// mirror of the writeback register.
reg_addr_t  exp_wb_rd;
logic       exp_wb_en;
word_t      exp_wb_value;

function automatic word_t expected_alu(alu_op_t op, logic alt, word_t a, word_t b);
    int unsigned sh;
    sh = b % 32;
    case (op)
        ALU_ADD:  return alt ? a - b : a + b;
        ALU_SLL:  return a << sh;
        ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
        ALU_XOR:  return a ^ b;
        ALU_SRL: begin
            if (!alt) return a >> sh;
            return (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh)); // refill with sign.
        end
        ALU_OR:   return a | b;
        ALU_AND:  return a & b;
        ALU_LUI:  return b;
        default:  return '0;
    endcase
endfunction

function automatic word_t forwarded_value(reg_addr_t rs, word_t value);
    if (rs == REG_ZERO) return value;
    if (exp_ex_wbk && exp_ex_rd == rs) return exp_ex_result; // younger result first.
    if (exp_wb_en && exp_wb_rd == rs) return exp_wb_value;
    return value;
endfunction

function automatic word_t extend_load(word_t data, word_t addr, mem_width_t width, logic zext);
    word_t byte_lane;
    word_t half_lane;
    byte_lane = data >> (8 * addr[1:0]);
    half_lane = data >> (16 * addr[1]);
    case (width)
        MEM_BYTE: return zext ? {24'h0, byte_lane[7:0]}
                              : {{24{byte_lane[7]}}, byte_lane[7:0]};
        MEM_HALF: return zext ? {16'h0, half_lane[15:0]}
                              : {{16{half_lane[15]}}, half_lane[15:0]};
        default:  return data;
    endcase
endfunction

task automatic reset_model();
    exp_ex_read = 1'b0;
    exp_ex_write = 1'b0;
    exp_ex_wbk = 1'b0;
    exp_ex_branch = BRANCH_NEVER;
    exp_wb_en = 1'b0;
endtask

// one clock edge using the inputs driven now.
task automatic advance_model();
    word_t fwd1;
    word_t fwd2;
    word_t op_a;
    word_t op_b;
    word_t wb_next;
    fwd1 = forwarded_value(rs1, rs1_value);
    fwd2 = forwarded_value(rs2, rs2_value);
    op_a = (alu_src1 == ALU_SRC1_PC) ? pc : fwd1;
    op_b = (alu_src2 == ALU_SRC2_IMM) ? imm : fwd2;
    wb_next = exp_ex_read ? extend_load(load_data, exp_ex_result, exp_ex_width, exp_ex_zext)
                          : exp_ex_result;
    if (stall) return;
    exp_wb_rd = exp_ex_rd;
    exp_wb_en = exp_ex_wbk;
    exp_wb_value = wb_next;
    exp_ex_rd = rd;
    exp_ex_wbk = rd_writeback && !flush;
    exp_ex_result = expected_alu(alu_op, alu_sub_sra, op_a, op_b);
    exp_ex_store = fwd2;
    if (branch_pc_src == BRANCH_PC_SRC_RS1) begin
        exp_ex_bpc = rs1_value + imm; // base register before bypass.
    end else begin
        exp_ex_bpc = pc + imm;
    end
    exp_ex_read = mem_read_en && !flush;
    exp_ex_write = mem_write_en && !flush;
    exp_ex_width = mem_width;
    exp_ex_zext = mem_zero_extend;
    exp_ex_branch = flush ? BRANCH_NEVER : branch_op;
endtask

`endif

/* dv/tb_rv32_exec_top.sv */
`timescale 1ns/1ps

module tb_rv32_exec_top;
    import rv32_types_pkg::*;
    import rv32_ctrl_pkg::*;

    localparam int RESET_TIMEOUT = 8;
    localparam int WATCHDOG_NS = 20000;

    logic       clk, rst_n, stall, flush;
    logic       alu_sub_sra, alu_src1, alu_src2, branch_pc_src;
    logic       mem_read_en, mem_write_en, mem_zero_extend, rd_writeback;
    reg_addr_t  rs1, rs2, rd, wb_rd;
    word_t      rs1_value, rs2_value, pc, imm, load_data;
    alu_op_t    alu_op;
    mem_width_t mem_width;
    branch_op_t branch_op, branch_op_out;
    logic       mem_read_en_out, mem_write_en_out, wb_en;
    word_t      mem_addr, store_data, branch_pc, wb_value;

    logic [31:0] lfsr_state;
    int          check_count;
    int          error_count;
    int          test_count;

    `include "rv32_exec_model.svh"

    rv32_exec_top rv32_exec_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("simulation still running after %0d ns, stopped", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_reg(input reg_addr_t actual, input reg_addr_t expected, input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s is x%0d, expected x%0d", $time, what, actual,
                     expected);
        end
    endtask

    task automatic check_branch(input branch_op_t actual, input branch_op_t expected,
                                input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s is %s, expected %s", $time, what, actual.name(),
                     expected.name());
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic drive_random(input logic fwd_on, input logic load_on, input logic flush_on,
                                input logic stall_on, input logic sweep_ops, input int step);
        logic [1:0] mem_kind;
        rs1 = reg_addr_t'(take_bits(3)); // x0..x7 keeps bypass hits frequent.
        rs2 = reg_addr_t'(take_bits(3));
        rd = reg_addr_t'(take_bits(3));
        rs1_value = take_bits(32);
        rs2_value = take_bits(32);
        pc = take_bits(32);
        imm = take_bits(32);
        load_data = take_bits(32);
        alu_op = alu_op_t'(4'(sweep_ops ? step % 9 : take_bits(4) % 9));
        alu_sub_sra = 1'(take_bits(1));
        alu_src1 = 1'(take_bits(1));
        alu_src2 = 1'(take_bits(1));
        branch_pc_src = 1'(take_bits(1));
        mem_zero_extend = 1'(take_bits(1));
        mem_width = mem_width_t'(2'(take_bits(2) % 3));
        branch_op = branch_op_t'(2'(take_bits(2)));
        mem_kind = 2'(take_bits(2));
        mem_read_en = load_on ? (mem_kind != 2'd0) : (mem_kind == 2'd1);
        mem_write_en = !load_on && mem_kind == 2'd2; // never together with a load.
        rd_writeback = fwd_on && take_bits(2) != 0;
        flush = flush_on && take_bits(3) == 0;
        stall = stall_on && take_bits(3) == 0;
    endtask

    task automatic compare_outputs();
        check_flag(mem_read_en_out, exp_ex_read, "mem_read_en_out");
        check_flag(mem_write_en_out, exp_ex_write, "mem_write_en_out");
        check_word(mem_addr, exp_ex_result, "mem_addr");
        check_word(store_data, exp_ex_store, "store_data");
        check_branch(branch_op_out, exp_ex_branch, "branch_op_out");
        check_word(branch_pc, exp_ex_bpc, "branch_pc");
        check_reg(wb_rd, exp_wb_rd, "wb_rd");
        check_flag(wb_en, exp_wb_en, "wb_en");
        check_word(wb_value, exp_wb_value, "wb_value");
    endtask

    task automatic apply_reset();
        int cycles;
        int errors_before;
        errors_before = error_count;
        rst_n = 1'b0;
        stall = 1'b1; // data fields stay unknown until the first real instruction.
        repeat (2) begin
            @(posedge clk);
        end
        #1;
        cycles = 0;
        while ((mem_read_en_out !== 1'b0 || mem_write_en_out !== 1'b0 || wb_en !== 1'b0
                || branch_op_out !== BRANCH_NEVER) && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (cycles >= RESET_TIMEOUT) begin
            error_count++;
            $display("control outputs still active %0d cycles into reset", RESET_TIMEOUT);
        end
        reset_model();
        compare_outputs();
        rst_n = 1'b1;
        test_count++;
        $display("test reset    done, %0d errors", error_count - errors_before);
    endtask

    task automatic run_test(input string name, input int cycles, input logic fwd_on,
                            input logic load_on, input logic flush_on, input logic stall_on,
                            input logic sweep_ops);
        int errors_before;
        errors_before = error_count;
        for (int n = 0; n < cycles; n++) begin
            drive_random(fwd_on, load_on, flush_on, stall_on, sweep_ops, n);
            advance_model();
            @(posedge clk);
            #1;
            compare_outputs();
        end
        test_count++;
        $display("test %-8s %0d cycles, %0d errors", name, cycles, error_count - errors_before);
    endtask

    initial begin
        lfsr_state = 32'ha8e5;
        check_count = 0;
        error_count = 0;
        test_count = 0;
        drive_random(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        apply_reset();
        run_test("alu", 54, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        run_test("forward", 200, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        run_test("load", 150, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        run_test("flush", 150, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
        run_test("stall", 150, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
        run_test("branch", 200, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0);
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* source/rv32_exec_top.sv */
`timescale 1ns/1ps

module rv32_exec_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      stall,
    input  logic                      flush,
    input  rv32_types_pkg::reg_addr_t rs1,
    input  rv32_types_pkg::reg_addr_t rs2,
    input  rv32_types_pkg::word_t     rs1_value,
    input  rv32_types_pkg::word_t     rs2_value,
    input  rv32_types_pkg::word_t     pc,
    input  rv32_types_pkg::word_t     imm,
    input  rv32_ctrl_pkg::alu_op_t    alu_op,
    input  logic                      alu_sub_sra,
    input  logic                      alu_src1,
    input  logic                      alu_src2,
    input  logic                      mem_read_en,
    input  logic                      mem_write_en,
    input  rv32_ctrl_pkg::mem_width_t mem_width,
    input  logic                      mem_zero_extend,
    input  rv32_ctrl_pkg::branch_op_t branch_op,
    input  logic                      branch_pc_src,
    input  rv32_types_pkg::reg_addr_t rd,
    input  logic                      rd_writeback,
    input  rv32_types_pkg::word_t     load_data,
    output logic                      mem_read_en_out,
    output logic                      mem_write_en_out,
    output rv32_types_pkg::word_t     mem_addr,
    output rv32_types_pkg::word_t     store_data,
    output rv32_ctrl_pkg::branch_op_t branch_op_out,
    output rv32_types_pkg::word_t     branch_pc,
    output rv32_types_pkg::reg_addr_t wb_rd,
    output logic                      wb_en,
    output rv32_types_pkg::word_t     wb_value
);
    rv32_ex_wb_if ex_wb ();

    rv32_execute execute_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .stall            (stall),
        .flush            (flush),
        .rs1              (rs1),
        .rs2              (rs2),
        .rs1_value        (rs1_value),
        .rs2_value        (rs2_value),
        .pc               (pc),
        .imm              (imm),
        .alu_op           (alu_op),
        .alu_sub_sra      (alu_sub_sra),
        .alu_src1         (alu_src1),
        .alu_src2         (alu_src2),
        .mem_read_en      (mem_read_en),
        .mem_write_en     (mem_write_en),
        .mem_width        (mem_width),
        .mem_zero_extend  (mem_zero_extend),
        .branch_op        (branch_op),
        .branch_pc_src    (branch_pc_src),
        .rd               (rd),
        .rd_writeback     (rd_writeback),
        .wb_rd            (wb_rd),
        .wb_en            (wb_en),
        .wb_value         (wb_value),
        .mem_write_en_out (mem_write_en_out),
        .branch_op_out    (branch_op_out),
        .branch_pc        (branch_pc),
        .store_data       (store_data),
        .ex_wb            (ex_wb.stage)
    );

    rv32_writeback writeback_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .load_data (load_data),
        .ex_wb     (ex_wb.sink),
        .wb_rd     (wb_rd),
        .wb_en     (wb_en),
        .wb_value  (wb_value)
    );

    assign mem_addr = ex_wb.result; // load and store address.
    assign mem_read_en_out = ex_wb.mem_read_en;

endmodule

/* source/rv32_writeback.sv */
`timescale 1ns/1ps

module rv32_writeback (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      stall,
    input  rv32_types_pkg::word_t     load_data,
    rv32_ex_wb_if.sink                ex_wb,
    output rv32_types_pkg::reg_addr_t wb_rd,
    output logic                      wb_en,
    output rv32_types_pkg::word_t     wb_value
);
    import rv32_types_pkg::*;
    import rv32_ctrl_pkg::*;

    logic [7:0]  load_byte;
    logic [15:0] load_half;
    word_t       load_value;
    word_t       result_sel;

    // lane picked by the low address bits.
    assign load_byte = load_data[{ex_wb.result[1:0], 3'b000} +: 8];
    assign load_half = load_data[{ex_wb.result[1], 4'b0000} +: 16];

    always_comb begin
        case (ex_wb.mem_width)
            MEM_BYTE: begin
                load_value = ex_wb.mem_zero_extend ? word_t'(load_byte)
                                                   : {{(XLEN-8){load_byte[7]}}, load_byte};
            end
            MEM_HALF: begin
                load_value = ex_wb.mem_zero_extend ? word_t'(load_half)
                                                   : {{(XLEN-16){load_half[15]}}, load_half};
            end
            MEM_WORD: load_value = load_data;
            default:  load_value = load_data;
        endcase
    end

    assign result_sel = ex_wb.mem_read_en ? load_value : ex_wb.result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_en <= 1'b0;
        end else if (!stall) begin
            wb_en <= ex_wb.rd_writeback;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wb_rd    <= ex_wb.rd;
            wb_value <= result_sel;
        end
    end

endmodule

/* source/rv32_execute.sv */
`timescale 1ns/1ps

module rv32_execute (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       stall,
    input  logic                       flush,
    input  rv32_types_pkg::reg_addr_t  rs1,
    input  rv32_types_pkg::reg_addr_t  rs2,
    input  rv32_types_pkg::word_t      rs1_value,
    input  rv32_types_pkg::word_t      rs2_value,
    input  rv32_types_pkg::word_t      pc,
    input  rv32_types_pkg::word_t      imm,
    input  rv32_ctrl_pkg::alu_op_t     alu_op,
    input  logic                       alu_sub_sra,
    input  logic                       alu_src1,
    input  logic                       alu_src2,
    input  logic                       mem_read_en,
    input  logic                       mem_write_en,
    input  rv32_ctrl_pkg::mem_width_t  mem_width,
    input  logic                       mem_zero_extend,
    input  rv32_ctrl_pkg::branch_op_t  branch_op,
    input  logic                       branch_pc_src,
    input  rv32_types_pkg::reg_addr_t  rd,
    input  logic                       rd_writeback,
    input  rv32_types_pkg::reg_addr_t  wb_rd,
    input  logic                       wb_en,
    input  rv32_types_pkg::word_t      wb_value,
    output logic                       mem_write_en_out,
    output rv32_ctrl_pkg::branch_op_t  branch_op_out,
    output rv32_types_pkg::word_t      branch_pc,
    output rv32_types_pkg::word_t      store_data,
    rv32_ex_wb_if.stage                ex_wb
);
    import rv32_types_pkg::*;
    import rv32_ctrl_pkg::*;

    word_t rs1_fwd;
    word_t rs2_fwd;
    word_t alu_result;
    word_t target;

    rv32_forward forward_i (
        .rs1       (rs1),
        .rs2       (rs2),
        .ex_rd     (ex_wb.rd),
        .wb_rd     (wb_rd),
        .ex_en     (ex_wb.rd_writeback),
        .wb_en     (wb_en),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .ex_value  (ex_wb.result),
        .wb_value  (wb_value),
        .rs1_fwd   (rs1_fwd),
        .rs2_fwd   (rs2_fwd)
    );

    rv32_alu alu_i (
        .op        (alu_op),
        .sub_sra   (alu_sub_sra),
        .src1      (alu_src1),
        .src2      (alu_src2),
        .pc        (pc),
        .rs1_value (rs1_fwd),
        .rs2_value (rs2_fwd),
        .imm       (imm),
        .result    (alu_result)
    );

    // base register is taken before bypass.
    assign target = ((branch_pc_src == BRANCH_PC_SRC_RS1) ? rs1_value : pc) + imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_wb.mem_read_en  <= 1'b0;
            mem_write_en_out   <= 1'b0;
            ex_wb.rd_writeback <= 1'b0;
            branch_op_out      <= BRANCH_NEVER;
        end else if (!stall) begin
            ex_wb.mem_read_en  <= mem_read_en && !flush;
            mem_write_en_out   <= mem_write_en && !flush;
            ex_wb.rd_writeback <= rd_writeback && !flush;
            branch_op_out      <= flush ? BRANCH_NEVER : branch_op;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_wb.rd              <= rd;
            ex_wb.result          <= alu_result;
            ex_wb.mem_width       <= mem_width;
            ex_wb.mem_zero_extend <= mem_zero_extend;
            store_data            <= rs2_fwd;
            branch_pc             <= target;
        end
    end

    flush_clears_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
        (flush && !stall) |=> (!ex_wb.mem_read_en && !mem_write_en_out
            && !ex_wb.rd_writeback && branch_op_out == BRANCH_NEVER))
        else $error("flushed instruction left control active");

    mem_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(ex_wb.mem_read_en && mem_write_en_out))
        else $error("load and store enabled together");

endmodule

/* source/rv32_forward.sv */
`timescale 1ns/1ps

module rv32_forward (
    input  rv32_types_pkg::reg_addr_t rs1,
    input  rv32_types_pkg::reg_addr_t rs2,
    input  rv32_types_pkg::reg_addr_t ex_rd,
    input  rv32_types_pkg::reg_addr_t wb_rd,
    input  logic                      ex_en,
    input  logic                      wb_en,
    input  rv32_types_pkg::word_t     rs1_value,
    input  rv32_types_pkg::word_t     rs2_value,
    input  rv32_types_pkg::word_t     ex_value,
    input  rv32_types_pkg::word_t     wb_value,
    output rv32_types_pkg::word_t     rs1_fwd,
    output rv32_types_pkg::word_t     rs2_fwd
);
    import rv32_types_pkg::*;

    // execute register wins over writeback, the younger result is newer.
    function automatic word_t bypass(reg_addr_t rs, word_t value);
        if (rs == REG_ZERO) return value;
        if (ex_en && ex_rd == rs) return ex_value;
        if (wb_en && wb_rd == rs) return wb_value;
        return value;
    endfunction

    always_comb begin
        rs1_fwd = bypass(rs1, rs1_value);
        rs2_fwd = bypass(rs2, rs2_value);
    end

    rs1_zero_check: assert final (rs1 != REG_ZERO || rs1_fwd == rs1_value)
        else $error("x0 source on rs1 took a bypassed value");
    rs2_zero_check: assert final (rs2 != REG_ZERO || rs2_fwd == rs2_value)
        else $error("x0 source on rs2 took a bypassed value");

endmodule

/* source/rv32_alu.sv */
`timescale 1ns/1ps

module rv32_alu (
    input  rv32_ctrl_pkg::alu_op_t op,
    input  logic                   sub_sra,
    input  logic                   src1,
    input  logic                   src2,
    input  rv32_types_pkg::word_t  pc,
    input  rv32_types_pkg::word_t  rs1_value,
    input  rv32_types_pkg::word_t  rs2_value,
    input  rv32_types_pkg::word_t  imm,
    output rv32_types_pkg::word_t  result
);
    import rv32_types_pkg::*;
    import rv32_ctrl_pkg::*;

    word_t  opa;
    word_t  opb;
    shamt_t shamt;

    assign opa = (src1 == ALU_SRC1_PC) ? pc : rs1_value;
    assign opb = (src2 == ALU_SRC2_IMM) ? imm : rs2_value;
    assign shamt = opb[SHAMT_W-1:0];

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = sub_sra ? opa - opb : opa + opb;
            end
            ALU_SLL:  result = opa << shamt;
            ALU_SLT:  result = word_t'($signed(opa) < $signed(opb));
            ALU_SLTU: result = word_t'(opa < opb);
            ALU_XOR:  result = opa ^ opb;
            ALU_SRL: begin
                if (sub_sra) begin
                    result = word_t'($signed(opa) >>> shamt); // sign bit fills.
                end else begin
                    result = opa >> shamt;
                end
            end
            ALU_OR:   result = opa | opb;
            ALU_AND:  result = opa & opb;
            ALU_LUI:  result = opb;
            default:  result = '0;
        endcase
    end

endmodule

/* source/rv32_ex_wb_if.sv */
`timescale 1ns/1ps

interface rv32_ex_wb_if;
    import rv32_types_pkg::*;
    import rv32_ctrl_pkg::*;

    reg_addr_t  rd;
    logic       rd_writeback;
    word_t      result;          // alu result, also the load address.
    logic       mem_read_en;
    mem_width_t mem_width;
    logic       mem_zero_extend;

    modport stage (
        output rd, rd_writeback, result,
        output mem_read_en, mem_width, mem_zero_extend
    );

    modport sink (
        input rd, rd_writeback, result,
        input mem_read_en, mem_width, mem_zero_extend
    );

endinterface

/* source/rv32_ctrl_pkg.sv */
package rv32_ctrl_pkg;

    // low three bits follow funct3 of the op/op-imm group.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0, // add, or sub with sub_sra.
        ALU_SLL  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SRL  = 4'd5, // logical, or arithmetic with sub_sra.
        ALU_OR   = 4'd6,
        ALU_AND  = 4'd7,
        ALU_LUI  = 4'd8  // operand b passes through.
    } alu_op_t;

    typedef enum logic [1:0] {
        BRANCH_NEVER   = 2'd0,
        BRANCH_ZERO    = 2'd1,
        BRANCH_NONZERO = 2'd2,
        BRANCH_ALWAYS  = 2'd3
    } branch_op_t;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_width_t;

    localparam logic ALU_SRC1_PC = 1'b1;       // 0 selects rs1.
    localparam logic ALU_SRC2_IMM = 1'b1;      // 0 selects rs2.
    localparam logic BRANCH_PC_SRC_RS1 = 1'b1; // 0 selects pc as base.

endpackage

/* source/rv32_types_pkg.sv */
package rv32_types_pkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W = 5;

    // data or address word of the datapath.
    typedef logic [XLEN-1:0] word_t;

    // index into the integer register file.
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // shift amount taken from the low bits of operand b.
    typedef logic [SHAMT_W-1:0] shamt_t;

    localparam reg_addr_t REG_ZERO = '0; // hardwired zero, never forwarded.

endpackage
